// File: rtl/vgaPkg.sv
package vgaPkg;

    // 640x480 at 60 Hz with a 25 MHz pixel clock
    localparam int hTotal     = 800;
    localparam int hVisible   = 640;
    localparam int hSyncStart = 656;
    localparam int hSyncLen   = 96;

    localparam int vTotal     = 525;
    localparam int vVisible   = 480;
    localparam int vSyncStart = 490;
    localparam int vSyncLen   = 2;

    localparam logic syncActive = 1'b0;  // both pulses are active low

    typedef logic [9:0] pixelX_t;
    typedef logic [9:0] pixelY_t;

    // 4 bits each, red in the top nibble
    typedef logic [11:0] rgb_t;

endpackage

// File: rtl/gamePkg.sv
package gamePkg;

    localparam int cellSize = 10;  // pixels per cell side
    localparam int gridCols = 64;
    localparam int gridRows = 48;

    typedef logic [5:0] cellX_t;
    typedef logic [5:0] cellY_t;

    // bit 1 set means a horizontal move
    typedef enum logic [1:0] {
        dirUp    = 2'd0,
        dirDown  = 2'd1,
        dirLeft  = 2'd2,
        dirRight = 2'd3
    } direction_t;

    localparam logic [7:0] keyUp      = 8'h75;
    localparam logic [7:0] keyDown    = 8'h72;
    localparam logic [7:0] keyLeft    = 8'h6B;
    localparam logic [7:0] keyRight   = 8'h74;
    localparam logic [7:0] keyRestart = 8'h29;  // space bar

    localparam vgaPkg::rgb_t colBackground = 12'hFFF;
    localparam vgaPkg::rgb_t colSnake      = 12'h000;
    localparam vgaPkg::rgb_t colApple      = 12'h0F0;
    localparam vgaPkg::rgb_t colBlank      = 12'h000;

    // head in column 3, body trailing to the left along the top row
    localparam int startHeadX  = 3;
    localparam int startY      = 0;
    localparam int startLength = 4;
    localparam int startAppleX = 6;
    localparam int startAppleY = 0;

endpackage

// File: rtl/scanTimer.sv
`timescale 1ns/1ps

module scanTimer (
    input  logic            clk25,
    input  logic            reset,
    output gamePkg::cellX_t cellCol,
    output gamePkg::cellY_t cellRow,
    output logic [3:0]      inCellX,
    output logic [3:0]      inCellY,
    output logic            active,
    output logic            hsyncRaw,
    output logic            vsyncRaw,
    output logic            frameTick
);
    import vgaPkg::*;
    import gamePkg::*;

    pixelX_t hCount;
    pixelY_t vCount;
    logic    lineEnd;
    logic    frameEnd;

    assign lineEnd  = (hCount == pixelX_t'(hTotal - 1));
    assign frameEnd = (vCount == pixelY_t'(vTotal - 1));

    // horizontal position, cell column follows without a divider
    always_ff @(posedge clk25) begin
        if (reset || lineEnd) begin
            hCount  <= '0;
            inCellX <= '0;
            cellCol <= '0;
        end else begin
            hCount <= hCount + 1'b1;
            if (inCellX == 4'(cellSize - 1)) begin
                inCellX <= '0;
                cellCol <= cellCol + 1'b1;  // wraps harmlessly in blanking
            end else begin
                inCellX <= inCellX + 1'b1;
            end
        end
    end

    always_ff @(posedge clk25) begin
        if (reset || (lineEnd && frameEnd)) begin
            vCount  <= '0;
            inCellY <= '0;
            cellRow <= '0;
        end else if (lineEnd) begin
            vCount <= vCount + 1'b1;
            if (inCellY == 4'(cellSize - 1)) begin
                inCellY <= '0;
                cellRow <= cellRow + 1'b1;
            end else begin
                inCellY <= inCellY + 1'b1;
            end
        end
    end

    assign active   = (hCount < pixelX_t'(hVisible)) && (vCount < pixelY_t'(vVisible));
    assign hsyncRaw = (hCount >= pixelX_t'(hSyncStart) &&
                       hCount < pixelX_t'(hSyncStart + hSyncLen)) ? syncActive : !syncActive;
    assign vsyncRaw = (vCount >= pixelY_t'(vSyncStart) &&
                       vCount < pixelY_t'(vSyncStart + vSyncLen)) ? syncActive : !syncActive;

    // first cycle of the first blank line
    assign frameTick = (hCount == '0) && (vCount == pixelY_t'(vVisible));

endmodule

// File: rtl/keyDecode.sv
`timescale 1ns/1ps

module keyDecode (
    input  logic                clk25,
    input  logic                reset,
    input  logic                keyStrobe,
    input  logic [7:0]          keyCode,
    input  gamePkg::direction_t lastDir,
    output logic                turnReq,
    output logic                restartReq,
    output gamePkg::direction_t turnDir
);
    import gamePkg::*;

    direction_t keyDir;
    logic       isArrow;
    logic       accept;

    always_comb begin
        isArrow = 1'b1;
        keyDir  = dirUp;
        case (keyCode)
            keyUp:    keyDir = dirUp;
            keyDown:  keyDir = dirDown;
            keyLeft:  keyDir = dirLeft;
            keyRight: keyDir = dirRight;
            default:  isArrow = 1'b0;
        endcase
    end

    // perpendicular when one is vertical and the other horizontal
    assign accept = keyStrobe && isArrow && (keyDir[1] != lastDir[1]);

    always_ff @(posedge clk25) begin
        if (reset) begin
            turnReq    <= 1'b0;
            restartReq <= 1'b0;
        end else begin
            turnReq    <= accept;
            restartReq <= keyStrobe && (keyCode == keyRestart);
        end
    end

    always_ff @(posedge clk25) begin
        if (accept) turnDir <= keyDir;
    end

endmodule

// File: rtl/snakeStep.sv
`timescale 1ns/1ps

module snakeStep #(
    parameter int maxLength  = 8,
    parameter int stepFrames = 6
) (
    input  logic                clk25,
    input  logic                reset,
    input  logic                frameTick,
    input  logic                turnReq,
    input  logic                restartReq,
    input  gamePkg::direction_t turnDir,
    output gamePkg::direction_t lastDir,
    output gamePkg::cellX_t     segX [maxLength],
    output gamePkg::cellY_t     segY [maxLength],
    output logic [3:0]          length,
    output gamePkg::cellX_t     appleX,
    output gamePkg::cellY_t     appleY,
    output logic                gameOver
);
    import gamePkg::*;

    localparam int moveW = $clog2(stepFrames) + 1;

    direction_t       pendDir;
    logic [moveW-1:0] moveCount;
    logic [15:0]      frameCount;
    logic [15:0]      frameNext;
    cellX_t           headX;
    cellY_t           headY;
    logic             wallHit;
    logic             bodyHit;
    logic             eat;
    logic             moveDue;

    assign frameNext = frameCount + 1'b1;  // counts the tick being handled
    assign moveDue   = frameTick && !gameOver && (moveCount == moveW'(stepFrames - 1));
    assign eat       = (headX == appleX) && (headY == appleY);

    // next head cell and what it runs into
    always_comb begin
        headX   = segX[0];
        headY   = segY[0];
        wallHit = 1'b0;
        bodyHit = 1'b0;
        case (pendDir)
            dirUp:    if (segY[0] == '0) wallHit = 1'b1; else headY = segY[0] - 1'b1;
            dirDown:  if (segY[0] == cellY_t'(gridRows - 1)) wallHit = 1'b1;
                      else headY = segY[0] + 1'b1;
            dirLeft:  if (segX[0] == '0) wallHit = 1'b1; else headX = segX[0] - 1'b1;
            default:  if (segX[0] == cellX_t'(gridCols - 1)) wallHit = 1'b1;
                      else headX = segX[0] + 1'b1;
        endcase
        for (int i = 0; i < maxLength; i++) begin
            if (i < int'(length) && segX[i] == headX && segY[i] == headY) bodyHit = 1'b1;
        end
    end

    always_ff @(posedge clk25) begin
        if (reset) frameCount <= '0;
        else if (frameTick) frameCount <= frameNext;  // not cleared by restart
    end

    always_ff @(posedge clk25) begin
        if (reset || (restartReq && gameOver)) begin
            gameOver  <= 1'b0;
            length    <= 4'(startLength);
            pendDir   <= dirRight;
            lastDir   <= dirRight;
            moveCount <= '0;
            appleX    <= cellX_t'(startAppleX);
            appleY    <= cellY_t'(startAppleY);
            for (int i = 0; i < maxLength; i++) begin
                segX[i] <= (i < startLength) ? cellX_t'(startHeadX - i) : '0;
                segY[i] <= cellY_t'(startY);
            end
        end else begin
            if (turnReq) pendDir <= turnDir;
            if (moveDue) begin
                moveCount <= '0;
                if (wallHit || bodyHit) begin
                    gameOver <= 1'b1;  // freeze where we are
                end else begin
                    lastDir <= pendDir;
                    segX[0] <= headX;
                    segY[0] <= headY;
                    for (int i = 1; i < maxLength; i++) begin
                        segX[i] <= segX[i-1];
                        segY[i] <= segY[i-1];
                    end
                    if (eat) begin
                        if (int'(length) < maxLength) length <= length + 1'b1;
                        appleX <= cellX_t'(frameNext % gridCols);
                        appleY <= cellY_t'(frameNext % gridRows);
                    end
                end
            end else if (frameTick && !gameOver) begin
                moveCount <= moveCount + 1'b1;
            end
        end
    end

endmodule

// File: rtl/pixelRender.sv
`timescale 1ns/1ps

module pixelRender #(
    parameter int maxLength = 8
) (
    input  logic            clk25,
    input  logic            reset,
    input  logic            active,
    input  logic            hsyncRaw,
    input  logic            vsyncRaw,
    input  gamePkg::cellX_t cellCol,
    input  gamePkg::cellY_t cellRow,
    input  gamePkg::cellX_t segX [maxLength],
    input  gamePkg::cellY_t segY [maxLength],
    input  logic [3:0]      length,
    input  gamePkg::cellX_t appleX,
    input  gamePkg::cellY_t appleY,
    output logic [3:0]      vgaRed,
    output logic [3:0]      vgaGreen,
    output logic [3:0]      vgaBlue,
    output logic            hsync,
    output logic            vsync
);
    import vgaPkg::*;
    import gamePkg::*;

    rgb_t pixColour;
    logic onSnake;

    always_comb begin
        onSnake = 1'b0;
        for (int i = 0; i < maxLength; i++) begin
            if (i < int'(length) && segX[i] == cellCol && segY[i] == cellRow) onSnake = 1'b1;
        end
        if (!active) pixColour = colBlank;
        else if (onSnake) pixColour = colSnake;  // snake drawn over the apple
        else if (cellCol == appleX && cellRow == appleY) pixColour = colApple;
        else pixColour = colBackground;
    end

    always_ff @(posedge clk25) begin
        if (reset) begin
            {vgaRed, vgaGreen, vgaBlue} <= colBlank;
            hsync <= !syncActive;
            vsync <= !syncActive;
        end else begin
            {vgaRed, vgaGreen, vgaBlue} <= pixColour;
            hsync <= hsyncRaw;  // keeps syncs aligned with colour
            vsync <= vsyncRaw;
        end
    end

endmodule

// File: rtl/snakeTop.sv
`timescale 1ns/1ps

module snakeTop #(
    parameter int maxLength  = 8,
    parameter int stepFrames = 6
) (
    input  logic       clk25,
    input  logic       reset,
    input  logic       keyStrobe,
    input  logic [7:0] keyCode,
    output logic [3:0] vgaRed,
    output logic [3:0] vgaGreen,
    output logic [3:0] vgaBlue,
    output logic       hsync,
    output logic       vsync,
    output logic [3:0] length,    // shown on the LEDs as the score
    output logic       gameOver
);
    import gamePkg::*;

    cellX_t     cellCol;
    cellY_t     cellRow;
    logic       active;
    logic       hsyncRaw;
    logic       vsyncRaw;
    logic       frameTick;
    logic       turnReq;
    logic       restartReq;
    direction_t turnDir;
    direction_t lastDir;
    cellX_t     segX [maxLength];
    cellY_t     segY [maxLength];
    cellX_t     appleX;
    cellY_t     appleY;

    scanTimer scanTimer_i (
        .clk25(clk25), .reset(reset),
        .cellCol(cellCol), .cellRow(cellRow),
        .inCellX(), .inCellY(),  // no per-pixel detail inside a cell yet
        .active(active), .hsyncRaw(hsyncRaw), .vsyncRaw(vsyncRaw), .frameTick(frameTick)
    );

    keyDecode keyDecode_i (
        .clk25(clk25), .reset(reset), .keyStrobe(keyStrobe), .keyCode(keyCode),
        .lastDir(lastDir), .turnReq(turnReq), .restartReq(restartReq), .turnDir(turnDir)
    );

    snakeStep #(.maxLength(maxLength), .stepFrames(stepFrames)) snakeStep_i (
        .clk25(clk25), .reset(reset), .frameTick(frameTick),
        .turnReq(turnReq), .restartReq(restartReq), .turnDir(turnDir), .lastDir(lastDir),
        .segX(segX), .segY(segY), .length(length),
        .appleX(appleX), .appleY(appleY), .gameOver(gameOver)
    );

    pixelRender #(.maxLength(maxLength)) pixelRender_i (
        .clk25(clk25), .reset(reset), .active(active),
        .hsyncRaw(hsyncRaw), .vsyncRaw(vsyncRaw), .cellCol(cellCol), .cellRow(cellRow),
        .segX(segX), .segY(segY), .length(length), .appleX(appleX), .appleY(appleY),
        .vgaRed(vgaRed), .vgaGreen(vgaGreen), .vgaBlue(vgaBlue), .hsync(hsync), .vsync(vsync)
    );

endmodule

// File: tests/snakeTb_assert.sv
`timescale 1ns/1ps

module snakeTb_assert #(
    parameter int maxLength = 8
) (
    input logic       clk25,
    input logic       reset,
    input logic       hsync,
    input logic       vsync,
    input logic [3:0] vgaRed,
    input logic [3:0] vgaGreen,
    input logic [3:0] vgaBlue,
    input logic [3:0] length,
    input logic       gameOver
);
    logic [9:0]  lowCount;      // cycles hsync has been low
    logic [9:0]  periodCount;   // cycles since the last hsync fall
    logic        hsyncPrev;
    logic        seenFall;
    logic [18:0] vLowCount;     // cycles vsync has been low
    logic [18:0] vPeriodCount;  // cycles since the last vsync fall
    logic        vsyncPrev;
    logic        seenVFall;
    int          failCount = 0;  // failed assertions so far

    always_ff @(posedge clk25) begin
        if (reset) begin
            lowCount    <= '0;
            periodCount <= '0;
            hsyncPrev   <= 1'b1;
            seenFall    <= 1'b0;
        end else begin
            hsyncPrev <= hsync;
            lowCount  <= hsync ? 10'd0 : lowCount + 10'd1;
            if (!hsync && hsyncPrev) begin
                periodCount <= 10'd1;
                seenFall    <= 1'b1;
            end else begin
                periodCount <= periodCount + 10'd1;
            end
        end
    end

    // same idea for the frame pulse, 800 cycles per line
    always_ff @(posedge clk25) begin
        if (reset) begin
            vLowCount    <= '0;
            vPeriodCount <= '0;
            vsyncPrev    <= 1'b1;
            seenVFall    <= 1'b0;
        end else begin
            vsyncPrev <= vsync;
            vLowCount <= vsync ? 19'd0 : vLowCount + 19'd1;
            if (!vsync && vsyncPrev) begin
                vPeriodCount <= 19'd1;
                seenVFall    <= 1'b1;
            end else begin
                vPeriodCount <= vPeriodCount + 19'd1;
            end
        end
    end

    hsyncWidth: assert property (@(posedge clk25) disable iff (reset)
        (hsync && !hsyncPrev) |-> lowCount == 10'd96)
        else begin
            failCount++;
            $error("hsync pulse width is not 96 cycles");
        end

    hsyncPeriod: assert property (@(posedge clk25) disable iff (reset)
        (seenFall && !hsync && hsyncPrev) |-> periodCount == 10'd800)
        else begin
            failCount++;
            $error("hsync period is not 800 cycles");
        end

    vsyncWidth: assert property (@(posedge clk25) disable iff (reset)
        (vsync && !vsyncPrev) |-> vLowCount == 19'd1600)
        else begin
            failCount++;
            $error("vsync pulse width is not 2 lines");
        end

    vsyncPeriod: assert property (@(posedge clk25) disable iff (reset)
        (seenVFall && !vsync && vsyncPrev) |-> vPeriodCount == 19'd420000)
        else begin
            failCount++;
            $error("vsync period is not 525 lines");
        end

    blankInSync: assert property (@(posedge clk25) disable iff (reset)
        (!hsync || !vsync) |-> {vgaRed, vgaGreen, vgaBlue} == 12'h000)
        else begin
            failCount++;
            $error("colour is not black during a sync pulse");
        end

    lengthLimit: assert property (@(posedge clk25) disable iff (reset)
        int'(length) <= maxLength)
        else begin
            failCount++;
            $error("snake length exceeds its maximum");
        end

    resetState: assert property (@(posedge clk25)
        $fell(reset) |-> (length == 4'd4) && !gameOver)
        else begin
            failCount++;
            $error("length or game over wrong right after reset");
        end

endmodule

bind snakeTop snakeTb_assert #(.maxLength(maxLength)) snakeTb_assert_i (
    .clk25(clk25), .reset(reset), .hsync(hsync), .vsync(vsync),
    .vgaRed(vgaRed), .vgaGreen(vgaGreen), .vgaBlue(vgaBlue),
    .length(length), .gameOver(gameOver)
);

// File: tests/snakeTb.sv
`timescale 1ns/1ps

module snakeTb;
    import gamePkg::*;

    localparam int timeoutCycles = 30 * 800 * 525;  // 30 frames

    logic       clk25;
    logic       reset;
    logic       keyStrobe;
    logic [7:0] keyCode;
    logic [3:0] vgaRed;
    logic [3:0] vgaGreen;
    logic [3:0] vgaBlue;
    logic       hsync;
    logic       vsync;
    logic [3:0] length;
    logic       gameOver;

    int hPos;
    int vPos;
    int frames;  // frame ticks seen since reset
    int cycles;
    int errors;
    int assertErrors;
    int eatFrame;

    snakeTop #(.maxLength(8), .stepFrames(1)) dut_i (
        .clk25(clk25), .reset(reset), .keyStrobe(keyStrobe), .keyCode(keyCode),
        .vgaRed(vgaRed), .vgaGreen(vgaGreen), .vgaBlue(vgaBlue),
        .hsync(hsync), .vsync(vsync), .length(length), .gameOver(gameOver)
    );

    initial clk25 = 1'b0;
    always #4 clk25 = ~clk25;

    // own copy of the raster position, same value as the DUT counters
    always @(posedge clk25) begin
        if (reset) begin
            hPos   <= 0;
            vPos   <= 0;
            frames <= 0;
        end else begin
            if (hPos == 799) begin
                hPos <= 0;
                vPos <= (vPos == 524) ? 0 : vPos + 1;
            end else begin
                hPos <= hPos + 1;
            end
            if (hPos == 0 && vPos == 480) frames <= frames + 1;
        end
    end

    always @(posedge clk25) begin
        cycles <= cycles + 1;
        if (cycles == timeoutCycles) begin
            $display("timeout: the test sequence did not finish within 30 frames");
            $display("Regression failed");
            $finish;
        end
    end

    task automatic checkValue(input string testName, input int expected, input int actual);
        assert (expected == actual)
        else begin
            errors++;
            $display("error %s expected %0h actual %0h", testName, expected, actual);
        end
    endtask

    // output is registered, so the colour of (x, y) shows one cycle later
    task automatic checkPixel(input string testName, input int x, input int y,
                              input int expected);
        do @(negedge clk25); while (!(hPos == x && vPos == y));
        @(negedge clk25);
        checkValue(testName, expected, int'({vgaRed, vgaGreen, vgaBlue}));
    endtask

    task automatic pressKey(input logic [7:0] code);
        @(posedge clk25);
        keyCode   <= code;
        keyStrobe <= 1'b1;
        @(posedge clk25);
        keyStrobe <= 1'b0;
    endtask

    task automatic checkStart(input string testName);
        checkValue({testName, " length"}, 4, int'(length));
        checkValue({testName, " gameOver"}, 0, int'(gameOver));
        checkPixel({testName, " head"}, 35, 5, 12'h000);
        checkPixel({testName, " apple"}, 65, 5, 12'h0F0);
        checkPixel({testName, " background"}, 105, 105, 12'hFFF);
    endtask

    initial begin
        reset     = 1'b1;
        keyStrobe = 1'b0;
        keyCode   = 8'h00;
        cycles    = 0;
        errors    = 0;
        repeat (5) @(posedge clk25);
        reset <= 1'b0;
        @(negedge clk25);

        checkStart("start");

        // three moves right reach the apple at (6,0)
        repeat (3) @(negedge vsync);
        eatFrame = frames;
        checkValue("eat length", 5, int'(length));
        checkPixel("eat apple", 10 * (eatFrame % 64) + 5, 10 * (eatFrame % 48) + 5, 12'h0F0);

        pressKey(keyDown);
        @(negedge vsync);
        pressKey(keyLeft);
        @(negedge vsync);
        pressKey(keyRight);  // reverse of left, dropped
        pressKey(keyUp);
        @(negedge vsync);
        checkValue("self hit gameOver", 1, int'(gameOver));
        checkValue("self hit length", 5, int'(length));

        pressKey(keyRestart);
        repeat (3) @(negedge clk25);
        checkStart("restart");

        pressKey(keyUp);  // head sits on row 0
        @(negedge vsync);
        checkValue("wall gameOver", 1, int'(gameOver));
        checkValue("wall length", 4, int'(length));

        repeat (10) @(negedge clk25);
        assertErrors = dut_i.snakeTb_assert_i.failCount;
        $display("checks done, value errors: %0d, assertion errors: %0d",
                 errors, assertErrors);
        if (errors == 0 && assertErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sim.f
rtl/vgaPkg.sv
rtl/gamePkg.sv
rtl/scanTimer.sv
rtl/keyDecode.sv
rtl/snakeStep.sv
rtl/pixelRender.sv
rtl/snakeTop.sv
tests/snakeTb_assert.sv
tests/snakeTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module snakeTb -o snakeSim

simOut=$(./obj_dir/snakeSim)
echo "$simOut"

# pass only if the testbench printed its pass line
if echo "$simOut" | grep -q "^Regression passed$"; then
    exit 0
else
    exit 1
fi
